//--- hw/se_pkg.sv
`default_nettype none

package se_pkg;

    // stream and frame geometry
    localparam int lanes        = 4;
    localparam int frame_pixels = 16;
    localparam int pool_shift   = 4;
    localparam int buf_addr_w   = 4;

    // flow control
    localparam int out_credits = 2;
    localparam int in_credits  = frame_pixels;
    localparam int credit_w    = $clog2(out_credits + 1);

    // configuration map, rows 0..7 then control word
    localparam int cfg_addr_w    = 4;
    localparam int cfg_ctrl_addr = 8;

    // arithmetic limits
    localparam int acc_w      = 20;
    localparam int reduce_max = 127;
    localparam int gate_w     = 7;
    localparam int gate_bias  = 64;
    localparam int gate_max   = 127;
    localparam int gate_frac  = 7;

    typedef logic signed [7:0] lane_t;

    // ch0 sits in the low byte
    typedef struct packed {
        lane_t ch3;
        lane_t ch2;
        lane_t ch1;
        lane_t ch0;
    } pixel_t;

    typedef struct packed {
        logic [gate_w-1:0] g3;
        logic [gate_w-1:0] g2;
        logic [gate_w-1:0] g1;
        logic [gate_w-1:0] g0;
    } gate_vec_t;

    typedef struct packed {
        logic [23:0] spare;
        logic [3:0]  expand_shift;
        logic [3:0]  reduce_shift;
    } cfg_ctrl_t;

    // same word seen as a weight row or as the control fields
    typedef union packed {
        pixel_t    row;
        cfg_ctrl_t ctrl;
    } cfg_word_u;

    // row j holds the weights feeding output j
    typedef pixel_t [3:0] weight_mat_t;

endpackage

`default_nettype wire

//--- hw/se_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module se_config_regs (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cfg_we,
    input  wire [se_pkg::cfg_addr_w-1:0]        cfg_addr,
    input  wire se_pkg::cfg_word_u              cfg_wdata,
    output se_pkg::weight_mat_t                 reduce_w,
    output se_pkg::weight_mat_t                 expand_w,
    output se_pkg::cfg_ctrl_t                   ctrl
);

    logic sel_reduce;
    logic sel_expand;
    logic sel_ctrl;

    // 0..3 reduce rows, 4..7 expand rows
    assign sel_reduce = cfg_we && (cfg_addr[3:2] == 2'b00);
    assign sel_expand = cfg_we && (cfg_addr[3:2] == 2'b01);
    assign sel_ctrl   = cfg_we &&
                        (cfg_addr == se_pkg::cfg_addr_w'(se_pkg::cfg_ctrl_addr));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reduce_w <= '0;
            expand_w <= '0;
            ctrl     <= '0;
        end else begin
            if (sel_reduce) begin
                reduce_w[cfg_addr[1:0]] <= cfg_wdata.row;
            end
            if (sel_expand) begin
                expand_w[cfg_addr[1:0]] <= cfg_wdata.row;
            end
            // spare bits are kept as written
            if (sel_ctrl) begin
                ctrl <= cfg_wdata.ctrl;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pool_accum.sv
`timescale 1ns/1ps
`default_nettype none

module pool_accum (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  in_valid,
    input  wire se_pkg::pixel_t  in_pixel,
    output logic                 pool_done,
    output se_pkg::pixel_t       pooled
);

    logic signed [se_pkg::acc_w-1:0] acc [se_pkg::lanes];
    logic signed [se_pkg::acc_w-1:0] sum [se_pkg::lanes];
    logic [se_pkg::buf_addr_w-1:0]   pix_cnt;
    logic                            last_pix;

    assign last_pix = in_valid &&
                      (pix_cnt == se_pkg::buf_addr_w'(se_pkg::frame_pixels - 1));

    // running sum including the current pixel
    always_comb begin
        for (int i = 0; i < se_pkg::lanes; i++) begin
            sum[i] = acc[i] + $signed(in_pixel[8*i +: 8]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt   <= '0;
            pool_done <= 1'b0;
            for (int i = 0; i < se_pkg::lanes; i++) begin
                acc[i] <= '0;
            end
        end else begin
            pool_done <= last_pix;
            if (in_valid) begin
                pix_cnt <= pix_cnt + 1'b1;
                for (int i = 0; i < se_pkg::lanes; i++) begin
                    acc[i] <= last_pix ? '0 : sum[i];
                end
            end
        end
    end

    // divide by 16, the average always fits a lane
    always_ff @(posedge clk) begin
        if (last_pix) begin
            for (int i = 0; i < se_pkg::lanes; i++) begin
                pooled[8*i +: 8] <= sum[i][se_pkg::pool_shift +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_buffer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr_en,
    input  wire se_pkg::pixel_t  wr_data,
    input  wire                  rd_en,
    output se_pkg::pixel_t       rd_data
);

    se_pkg::pixel_t                mem [se_pkg::frame_pixels];
    logic [se_pkg::buf_addr_w-1:0] wr_ptr;
    logic [se_pkg::buf_addr_w-1:0] rd_ptr;

    // pointers wrap naturally at the buffer depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= wr_data;
        if (rd_en) rd_data <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- hw/squeeze_fc.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_fc (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       pool_done,
    input  wire se_pkg::pixel_t       pooled,
    input  wire se_pkg::weight_mat_t  reduce_w,
    input  wire se_pkg::weight_mat_t  expand_w,
    input  wire se_pkg::cfg_ctrl_t    ctrl,
    input  wire                       gates_taken,
    output se_pkg::gate_vec_t         gates,
    output logic                      gates_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_reduce,
        st_expand
    } fc_state_t;

    fc_state_t                       state;
    logic [1:0]                      idx;
    se_pkg::pixel_t                  vec_in;
    se_pkg::pixel_t                  red_vec;
    se_pkg::pixel_t                  w_row;
    se_pkg::pixel_t                  x_vec;
    logic signed [se_pkg::acc_w-1:0] mac;
    logic signed [se_pkg::acc_w-1:0] red_shifted;
    logic signed [se_pkg::acc_w-1:0] exp_val;
    logic [7:0]                      red_val;
    logic [se_pkg::gate_w-1:0]       gate_val;

    // shared four-way MAC, one output channel per cycle
    always_comb begin
        w_row = (state == st_expand) ? expand_w[idx] : reduce_w[idx];
        x_vec = (state == st_expand) ? red_vec : vec_in;
        mac   = '0;
        for (int i = 0; i < se_pkg::lanes; i++) begin
            mac = mac + $signed(w_row[8*i +: 8]) * $signed(x_vec[8*i +: 8]);
        end
    end

    // relu, requantize and saturate for the reduce outputs
    always_comb begin
        red_shifted = mac >>> ctrl.reduce_shift;
        if (mac < 0) begin
            red_val = '0;
        end else if (red_shifted > se_pkg::reduce_max) begin
            red_val = 8'(se_pkg::reduce_max);
        end else begin
            red_val = red_shifted[7:0];
        end
    end

    // hard sigmoid on the expand outputs
    always_comb begin
        exp_val = (mac >>> ctrl.expand_shift) + se_pkg::acc_w'(se_pkg::gate_bias);
        if (exp_val < 0) begin
            gate_val = '0;
        end else if (exp_val > se_pkg::gate_max) begin
            gate_val = se_pkg::gate_w'(se_pkg::gate_max);
        end else begin
            gate_val = exp_val[se_pkg::gate_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            idx         <= '0;
            gates_ready <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (pool_done) begin
                        state <= st_reduce;
                        idx   <= '0;
                    end
                end
                st_reduce: begin
                    idx <= idx + 1'b1;
                    if (idx == 2'd3) state <= st_expand;
                end
                st_expand: begin
                    idx <= idx + 1'b1;
                    if (idx == 2'd3) state <= st_idle;
                end
                default: state <= st_idle;
            endcase

            // held until the scaler has read the whole frame
            if (state == st_expand && idx == 2'd3) begin
                gates_ready <= 1'b1;
            end else if (gates_taken) begin
                gates_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && pool_done) vec_in <= pooled;
        if (state == st_reduce) red_vec[8*idx +: 8] <= red_val;
        if (state == st_expand) gates[se_pkg::gate_w*idx +: se_pkg::gate_w] <= gate_val;
    end

endmodule

`default_nettype wire

//--- hw/channel_scale.sv
`timescale 1ns/1ps
`default_nettype none

module channel_scale (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire se_pkg::gate_vec_t   gates,
    input  wire                      gates_ready,
    input  wire                      out_credit,
    output logic                     rd_en,
    input  wire se_pkg::pixel_t      rd_data,
    output logic                     in_credit,
    output logic                     gates_taken,
    output logic                     out_valid,
    output se_pkg::pixel_t           out_pixel
);

    logic [se_pkg::credit_w-1:0]   credit_cnt;
    logic [se_pkg::credit_w-1:0]   in_flight;
    logic [se_pkg::buf_addr_w-1:0] rd_cnt;
    logic                          s1_valid;
    logic signed [15:0]            prod [se_pkg::lanes];
    se_pkg::pixel_t                scaled;

    // a read needs a credit not already claimed by a pixel in the pipe
    assign in_flight = se_pkg::credit_w'(s1_valid) + se_pkg::credit_w'(out_valid);
    assign rd_en     = gates_ready && !gates_taken && (credit_cnt > in_flight);

    // gates are 0..127, i.e. 7 fractional bits
    always_comb begin
        for (int i = 0; i < se_pkg::lanes; i++) begin
            prod[i] = $signed(rd_data[8*i +: 8]) *
                      $signed({1'b0, gates[se_pkg::gate_w*i +: se_pkg::gate_w]});
            scaled[8*i +: 8] = prod[i][se_pkg::gate_frac +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt  <= se_pkg::credit_w'(se_pkg::out_credits);
            rd_cnt      <= '0;
            s1_valid    <= 1'b0;
            out_valid   <= 1'b0;
            in_credit   <= 1'b0;
            gates_taken <= 1'b0;
        end else begin
            credit_cnt  <= credit_cnt - se_pkg::credit_w'(out_valid)
                                      + se_pkg::credit_w'(out_credit);
            s1_valid    <= rd_en;
            out_valid   <= s1_valid;
            in_credit   <= rd_en;
            gates_taken <= rd_en &&
                           (rd_cnt == se_pkg::buf_addr_w'(se_pkg::frame_pixels - 1));
            if (rd_en) rd_cnt <= rd_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) out_pixel <= scaled;
    end

endmodule

`default_nettype wire

//--- hw/se_block_top.sv
`timescale 1ns/1ps
`default_nettype none

module se_block_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           cfg_we,
    input  wire [se_pkg::cfg_addr_w-1:0]  cfg_addr,
    input  wire se_pkg::cfg_word_u        cfg_wdata,
    input  wire                           in_valid,
    input  wire se_pkg::pixel_t           in_pixel,
    output logic                          in_credit,
    output logic                          out_valid,
    output se_pkg::pixel_t                out_pixel,
    input  wire                           out_credit
);

    se_pkg::weight_mat_t reduce_w;
    se_pkg::weight_mat_t expand_w;
    se_pkg::cfg_ctrl_t   ctrl;
    logic                pool_done;
    se_pkg::pixel_t      pooled;
    logic                rd_en;
    se_pkg::pixel_t      rd_data;
    se_pkg::gate_vec_t   gates;
    logic                gates_ready;
    logic                gates_taken;

    se_config_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .reduce_w  (reduce_w),
        .expand_w  (expand_w),
        .ctrl      (ctrl)
    );

    pool_accum u_pool (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .pool_done (pool_done),
        .pooled    (pooled)
    );

    // frame is kept here until its gates are known
    pixel_buffer u_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (in_valid),
        .wr_data (in_pixel),
        .rd_en   (rd_en),
        .rd_data (rd_data)
    );

    squeeze_fc u_fc (
        .clk         (clk),
        .rst_n       (rst_n),
        .pool_done   (pool_done),
        .pooled      (pooled),
        .reduce_w    (reduce_w),
        .expand_w    (expand_w),
        .ctrl        (ctrl),
        .gates_taken (gates_taken),
        .gates       (gates),
        .gates_ready (gates_ready)
    );

    channel_scale u_scale (
        .clk         (clk),
        .rst_n       (rst_n),
        .gates       (gates),
        .gates_ready (gates_ready),
        .out_credit  (out_credit),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .in_credit   (in_credit),
        .gates_taken (gates_taken),
        .out_valid   (out_valid),
        .out_pixel   (out_pixel)
    );

endmodule

`default_nettype wire

//--- tb/se_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module se_tb_clk (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/se_tb.sv
`timescale 1ns/1ps
`default_nettype none

module se_tb;

    logic                          clk;
    logic                          rst_n;
    logic                          cfg_we;
    logic [se_pkg::cfg_addr_w-1:0] cfg_addr;
    se_pkg::cfg_word_u             cfg_wdata;
    logic                          in_valid;
    se_pkg::pixel_t                in_pixel;
    logic                          in_credit;
    logic                          out_valid;
    se_pkg::pixel_t                out_pixel;
    logic                          out_credit;

    // model copy of the configuration
    logic signed [7:0] rw [4][4];
    logic signed [7:0] ew [4][4];
    int                rs;
    int                es;

    se_pkg::pixel_t src_q [$];
    se_pkg::pixel_t exp_q [$];
    int             due_q [$];
    se_pkg::pixel_t exp_head;
    logic           exp_valid;
    int             src_credits;
    int             sent_cnt;
    int             pushed_cnt;
    int             out_cnt;
    int             held;
    int             cyc;
    int             stall_end;
    int             last_due;
    int             value_errs;
    int             proto_errs;

    se_tb_clk u_clk (.clk(clk));

    se_block_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .in_valid   (in_valid),
        .in_pixel   (in_pixel),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_credit (out_credit)
    );

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    // rows 0..3 reduce, 4..7 expand, then the shifts
    task automatic write_config(input int rlo, input int rspan, input int elo,
                                input int espan, input int rsh, input int esh);
        se_pkg::pixel_t    row;
        se_pkg::cfg_ctrl_t ctrl;
        @(negedge clk);
        for (int j = 0; j < 8; j++) begin
            for (int i = 0; i < se_pkg::lanes; i++) begin
                if (j < 4) begin
                    rw[j][i] = 8'(rlo + int'($urandom_range(rspan)));
                    row[8*i +: 8] = rw[j][i];
                end else begin
                    ew[j-4][i] = 8'(elo + int'($urandom_range(espan)));
                    row[8*i +: 8] = ew[j-4][i];
                end
            end
            cfg_we        = 1'b1;
            cfg_addr      = 4'(j);
            cfg_wdata.row = row;
            @(negedge clk);
        end
        ctrl              = '0;
        ctrl.reduce_shift = 4'(rsh);
        ctrl.expand_shift = 4'(esh);
        rs                = rsh;
        es                = esh;
        cfg_addr          = 4'(se_pkg::cfg_ctrl_addr);
        cfg_wdata.ctrl    = ctrl;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    // one frame of pixels plus its expected outputs
    task automatic queue_frame(input int base_lo, input int noise_lo);
        se_pkg::pixel_t pix [se_pkg::frame_pixels];
        se_pkg::pixel_t e;
        int             base [4];
        int             sum [4];
        int             avg [4];
        int             red [4];
        int             gate [4];
        int             acc;
        int             v;
        @(posedge clk);
        for (int c = 0; c < 4; c++) begin
            base[c] = base_lo + int'($urandom_range(63));
            sum[c]  = 0;
        end
        for (int p = 0; p < se_pkg::frame_pixels; p++) begin
            for (int c = 0; c < 4; c++) begin
                v = base[c] + noise_lo + int'($urandom_range(31));
                pix[p][8*c +: 8] = 8'(v);
                sum[c] += v;
            end
        end
        for (int c = 0; c < 4; c++) avg[c] = sum[c] >>> se_pkg::pool_shift;
        // relu, shift, saturate
        for (int j = 0; j < 4; j++) begin
            acc = 0;
            for (int i = 0; i < 4; i++) acc += int'(rw[j][i]) * avg[i];
            red[j] = (acc < 0) ? 0 : clamp(acc >>> rs, 0, 127);
        end
        // hard sigmoid
        for (int j = 0; j < 4; j++) begin
            acc = 0;
            for (int i = 0; i < 4; i++) acc += int'(ew[j][i]) * red[i];
            gate[j] = clamp((acc >>> es) + se_pkg::gate_bias, 0, se_pkg::gate_max);
        end
        for (int p = 0; p < se_pkg::frame_pixels; p++) begin
            for (int c = 0; c < 4; c++) begin
                v = int'($signed(pix[p][8*c +: 8])) * gate[c];
                e[8*c +: 8] = 8'(v >>> se_pkg::gate_frac);
            end
            src_q.push_back(pix[p]);
            exp_q.push_back(e);
            pushed_cnt++;
        end
    endtask

    task automatic wait_drain();
        while (out_cnt != pushed_cnt) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // credit-limited source and delayed-credit sink
    always @(negedge clk) begin
        if (rst_n) begin
            cyc++;
            if (in_credit) src_credits++;
            if (src_q.size() > 0 && src_credits > 0 && $urandom_range(3) != 0) begin
                in_valid = 1'b1;
                in_pixel = src_q.pop_front();
                src_credits--;
                sent_cnt++;
            end else begin
                in_valid = 1'b0;
            end
            if (out_valid) begin
                out_cnt++;
                held++;
                exp_valid = (exp_q.size() > 0);
                if (exp_valid) exp_head = exp_q.pop_front();
                // long credit stall in the third frame
                if (out_cnt == 40) stall_end = cyc + 50;
                v_due: begin
                    int due;
                    due = cyc + int'($urandom_range(6));
                    last_due = (due > last_due) ? due : last_due + 1;
                end
                due_q.push_back(last_due);
            end
            out_credit = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc && cyc >= stall_end) begin
                void'(due_q.pop_front());
                out_credit = 1'b1;
                held--;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (sent_cnt < se_pkg::frame_pixels) |-> (!out_valid && !in_credit))
    else begin
        proto_errs++;
        $display("output or input credit seen before the first frame was complete");
    end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> exp_valid)
    else begin
        proto_errs++;
        $display("an output pixel arrived with no expected pixel left");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && exp_valid) |-> (out_pixel == exp_head))
    else begin
        value_errs++;
        $display("Fail at %0t: out_pixel %h, expected %h", $time,
                 $sampled(out_pixel), $sampled(exp_head));
    end

    assert property (@(posedge clk) disable iff (!rst_n) held <= se_pkg::out_credits)
    else begin
        proto_errs++;
        $display("the stage sent more pixels than it had output credits for");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        src_credits <= se_pkg::in_credits)
    else begin
        proto_errs++;
        $display("more input credits came back than pixels were sent, count now %0d",
                 $sampled(src_credits));
    end

    initial begin
        void'($urandom(32'h9af32c96));
        rst_n       = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        in_valid    = 1'b0;
        in_pixel    = '0;
        out_credit  = 1'b0;
        exp_head    = '0;
        exp_valid   = 1'b0;
        src_credits = se_pkg::in_credits;
        sent_cnt    = 0;
        pushed_cnt  = 0;
        out_cnt     = 0;
        held        = 0;
        cyc         = 0;
        stall_end   = 0;
        last_due    = 0;
        value_errs  = 0;
        proto_errs  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // new weights every other frame so each pair runs back to back
        for (int f = 0; f < 8; f++) begin
            if (f % 2 == 0) begin
                wait_drain();
                write_config(-128, 255, -128, 255, 5 + int'($urandom_range(4)),
                             6 + int'($urandom_range(5)));
            end
            queue_frame(-32, -16);
        end
        // gates pinned at gate_max and then at zero
        wait_drain();
        write_config(127, 0, 100, 27, 0, 0);
        queue_frame(32, 0);
        wait_drain();
        write_config(127, 0, -128, 28, 0, 0);
        queue_frame(32, 0);
        wait_drain();
        repeat (10) @(posedge clk);
        assert (out_cnt == pushed_cnt && exp_q.size() == 0 && src_q.size() == 0)
        else begin
            proto_errs++;
            $display("not every input pixel came out, sent %0d received %0d",
                     sent_cnt, out_cnt);
        end
        $display("errors: %0d value, %0d protocol; %0d of %0d pixels out",
                 value_errs, proto_errs, out_cnt, pushed_cnt);
        if (value_errs + proto_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // ten frames of sixteen pixels
    initial begin
        repeat (10 * se_pkg::frame_pixels * 20 + 2000) @(posedge clk);
        $display("watchdog expired, the stream stalled or never finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/se_pkg.sv
hw/se_config_regs.sv
hw/pool_accum.sv
hw/pixel_buffer.sv
hw/squeeze_fc.sv
hw/channel_scale.sv
hw/se_block_top.sv
tb/se_tb_clk.sv
tb/se_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the SE stage testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module se_tb -f flist.f -o se_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/se_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$log"; then
    echo "no result line in $log"
    exit 1
fi
exit 0
